/* hw/tracklet_pkg.sv */
`default_nettype none

package tracklet_pkg;

    ////////////////////////////////////////
    // stub word layout
    ////////////////////////////////////////
    localparam int STUB_W = 36;
    localparam int R_W    = 12;     // signed local radius
    localparam int R_LSB  = 21;
    localparam int Z_W    = 7;      // signed local z
    localparam int Z_LSB  = 14;
    localparam int PHI_W  = 14;     // unsigned phi
    localparam int PHI_LSB = 0;

    // front stage results
    localparam int RABS_W = 13;
    localparam int DPHI_W = 16;
    localparam int DZ_W   = 12;

    // 1/dr lookup
    localparam int DRINV_ADDR_W = 10;
    localparam int DRINV_W      = 12;
    localparam int DRINV_SHIFT  = 20;   // entries hold 2^20 / dr

    ////////////////////////////////////////
    // track parameters
    ////////////////////////////////////////
    localparam int RINV_W  = 16;
    localparam int T_W     = 14;
    localparam int PHI0_W  = 18;
    localparam int Z0_W    = 14;
    localparam int TRACK_W = RINV_W + PHI0_W + Z0_W + T_W;   // 62, rinv on top

    localparam int RINV_SHIFT = 11;
    localparam int T_SHIFT    = 8;
    localparam int PROJ_SHIFT = 12;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_TRACK_LO   = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_TRACK_HI   = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_PASS_CNT   = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_REJECT_CNT = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_CLEAR      = 8'h10;   // write-only

endpackage

`default_nettype wire

/* hw/stub_delta_if.sv */
`default_nettype none

// deltas of one stub pair plus the inner stub values needed downstream
interface stub_delta_if;
    import tracklet_pkg::*;

    logic                     valid;
    logic signed [DPHI_W-1:0] delta_phi;
    logic signed [DZ_W-1:0]   delta_z;
    logic [DRINV_W-1:0]       dr_inv;       // 2^20 / dr, saturated
    logic [RABS_W-1:0]        r_a_abs;
    logic [PHI_W-1:0]         phi_a;
    logic signed [Z_W-1:0]    z_a;

    modport front (
        output valid, delta_phi, delta_z, dr_inv, r_a_abs, phi_a, z_a
    );

    modport sink (
        input valid, delta_phi, delta_z, dr_inv, r_a_abs, phi_a, z_a
    );

endinterface

`default_nettype wire

/* hw/stub_pair_front.sv */
`default_nettype none

module stub_pair_front #(
    parameter int KR_INNER = 981,
    parameter int KR_OUTER = 1515,
    parameter int KZ_INNER = 981,
    parameter int KZ_OUTER = 1515
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stub_valid,
    input  logic [tracklet_pkg::STUB_W-1:0]  inner_stub,
    input  logic [tracklet_pkg::STUB_W-1:0]  outer_stub,
    stub_delta_if.front                      delta
);
    import tracklet_pkg::*;

    // saturated reciprocal, address 0 treated as 1
    function automatic logic [DRINV_W-1:0] drinv_entry(input int a);
        int q;
        q = (1 << DRINV_SHIFT) / ((a > 0) ? a : 1);
        if (q > 2**DRINV_W - 1)
            q = 2**DRINV_W - 1;
        return q[DRINV_W-1:0];
    endfunction

    logic signed [R_W-1:0] r_a, r_b;
    logic signed [Z_W-1:0] z_a, z_b;
    logic [PHI_W-1:0]      phi_a, phi_b;

    logic                     valid_s1;
    logic [RABS_W-1:0]        r_a_abs_s1, r_b_abs_s1;
    logic signed [DPHI_W-1:0] delta_phi_s1;
    logic signed [DZ_W-1:0]   delta_z_s1;
    logic [PHI_W-1:0]         phi_a_s1;
    logic signed [Z_W-1:0]    z_a_s1;
    logic signed [RABS_W:0]   dr;

    logic [DRINV_W-1:0] drinv_rom [2**DRINV_ADDR_W];

    for (genvar a = 0; a < 2**DRINV_ADDR_W; a++) begin : g_rom
        localparam logic [DRINV_W-1:0] ENTRY = drinv_entry(a);
        assign drinv_rom[a] = ENTRY;
    end

    assign r_a   = inner_stub[R_LSB +: R_W];
    assign z_a   = inner_stub[Z_LSB +: Z_W];
    assign phi_a = inner_stub[PHI_LSB +: PHI_W];
    assign r_b   = outer_stub[R_LSB +: R_W];
    assign z_b   = outer_stub[Z_LSB +: Z_W];
    assign phi_b = outer_stub[PHI_LSB +: PHI_W];

    ////////////////////////////////////////
    // stage 1: radii and deltas
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset)
            valid_s1 <= 1'b0;
        else
            valid_s1 <= stub_valid;
    end

    always_ff @(posedge clk) begin
        r_a_abs_s1   <= RABS_W'(KR_INNER + r_a);
        r_b_abs_s1   <= RABS_W'(KR_OUTER + r_b);
        delta_phi_s1 <= DPHI_W'(phi_b) - DPHI_W'(phi_a);   // wraps into signed
        delta_z_s1   <= DZ_W'(KZ_OUTER - KZ_INNER) + z_b - z_a;
        phi_a_s1     <= phi_a;
        z_a_s1       <= z_a;
    end

    assign dr = signed'({1'b0, r_b_abs_s1}) - signed'({1'b0, r_a_abs_s1});

    ////////////////////////////////////////
    // stage 2: rom read, carry the rest
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset)
            delta.valid <= 1'b0;
        else
            delta.valid <= valid_s1;
    end

    always_ff @(posedge clk) begin
        delta.dr_inv    <= drinv_rom[dr[DRINV_ADDR_W-1:0]];
        delta.delta_phi <= delta_phi_s1;
        delta.delta_z   <= delta_z_s1;
        delta.r_a_abs   <= r_a_abs_s1;
        delta.phi_a     <= phi_a_s1;
        delta.z_a       <= z_a_s1;
    end

    // outer stub must sit further out than the inner one
    dr_positive: assert property (@(posedge clk) disable iff (reset) valid_s1 |-> dr > 0);

endmodule

`default_nettype wire

/* hw/curvature_unit.sv */
`default_nettype none

module curvature_unit (
    input  logic                                clk,
    stub_delta_if.sink                          delta,
    output logic signed [tracklet_pkg::RINV_W-1:0] rinv
);
    import tracklet_pkg::*;

    logic signed [DPHI_W+DRINV_W:0] prod;   // dphi * 1/dr

    always_ff @(posedge clk) begin
        prod <= delta.delta_phi * signed'({1'b0, delta.dr_inv});
    end

    // sign flip follows the phi convention of the disk seeds
    always_ff @(posedge clk) begin
        rinv <= RINV_W'(-(prod >>> RINV_SHIFT));
    end

endmodule

`default_nettype wire

/* hw/slope_unit.sv */
`default_nettype none

module slope_unit (
    input  logic                               clk,
    stub_delta_if.sink                         delta,
    output logic signed [tracklet_pkg::T_W-1:0] t
);
    import tracklet_pkg::*;

    logic signed [DZ_W+DRINV_W:0] prod;     // dz * 1/dr

    always_ff @(posedge clk) begin
        prod <= delta.delta_z * signed'({1'b0, delta.dr_inv});
    end

    always_ff @(posedge clk) begin
        t <= T_W'(prod >>> T_SHIFT);
    end

    // a zero reciprocal would flatten every track to t = 0
    drinv_nonzero: assert property (
        @(posedge clk) delta.valid |-> delta.dr_inv != '0
    );

endmodule

`default_nettype wire

/* hw/track_param_combiner.sv */
`default_nettype none

module track_param_combiner #(
    parameter int RINV_CUT = 7491,
    parameter int Z0_CUT   = 267
) (
    input  logic                                    clk,
    input  logic                                    reset,
    stub_delta_if.sink                              delta,
    input  logic signed [tracklet_pkg::RINV_W-1:0]  rinv,
    input  logic signed [tracklet_pkg::T_W-1:0]     t,
    output logic                                    track_valid,
    output logic                                    track_reject,
    output logic [tracklet_pkg::TRACK_W-1:0]        trackpar
);
    import tracklet_pkg::*;

    // inner stub values, delayed to line up with rinv and t
    logic                  valid_d1, valid_d2;
    logic [PHI_W-1:0]      phi_a_d1, phi_a_d2;
    logic signed [Z_W-1:0] z_a_d1, z_a_d2;
    logic [RABS_W-1:0]     r_abs_d1, r_abs_d2;

    logic                          valid_s1;
    logic signed [RINV_W-1:0]      rinv_s1;
    logic signed [T_W-1:0]         t_s1;
    logic [PHI_W-1:0]              phi_a_s1;
    logic signed [Z_W-1:0]         z_a_s1;
    logic signed [RINV_W+RABS_W:0] rinv_prod;
    logic signed [T_W+RABS_W:0]    t_prod;

    logic signed [PHI0_W-1:0] phi0;
    logic signed [Z0_W-1:0]   z0;
    logic                     pass;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
            valid_s1 <= 1'b0;
        end else begin
            valid_d1 <= delta.valid;
            valid_d2 <= valid_d1;
            valid_s1 <= valid_d2;
        end
    end

    always_ff @(posedge clk) begin
        phi_a_d1 <= delta.phi_a;
        phi_a_d2 <= phi_a_d1;
        z_a_d1   <= delta.z_a;
        z_a_d2   <= z_a_d1;
        r_abs_d1 <= delta.r_a_abs;
        r_abs_d2 <= r_abs_d1;
    end

    ////////////////////////////////////////
    // stage 1: project to the inner radius
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        rinv_s1   <= rinv;
        t_s1      <= t;
        phi_a_s1  <= phi_a_d2;
        z_a_s1    <= z_a_d2;
        rinv_prod <= rinv * signed'({1'b0, r_abs_d2});
        t_prod    <= t * signed'({1'b0, r_abs_d2});
    end

    ////////////////////////////////////////
    // stage 2: phi0, z0 and the cut
    ////////////////////////////////////////
    assign phi0 = PHI0_W'(signed'({1'b0, phi_a_s1}) + (rinv_prod >>> PROJ_SHIFT));
    assign z0   = Z0_W'(z_a_s1 - (t_prod >>> PROJ_SHIFT));

    assign pass = (rinv_s1 < RINV_CUT) && (rinv_s1 > -RINV_CUT)   // pt cut
               && (z0 < Z0_CUT) && (z0 > -Z0_CUT);                 // beam spot

    always_ff @(posedge clk) begin
        if (reset) begin
            track_valid  <= 1'b0;
            track_reject <= 1'b0;
        end else begin
            track_valid  <= valid_s1 && pass;
            track_reject <= valid_s1 && !pass;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s1 && pass)
            trackpar <= {rinv_s1, phi0, z0, t_s1};
    end

    pass_xor_reject: assert property (
        @(posedge clk) disable iff (reset) !(track_valid && track_reject)
    );

endmodule

`default_nettype wire

/* hw/axil_track_regs.sv */
`default_nettype none

module axil_track_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 track_valid,
    input  logic                                 track_reject,
    input  logic [tracklet_pkg::TRACK_W-1:0]     trackpar,
    input  logic [tracklet_pkg::AXI_ADDR_W-1:0]  s_axil_awaddr,
    input  logic                                 s_axil_awvalid,
    output logic                                 s_axil_awready,
    input  logic [tracklet_pkg::AXI_DATA_W-1:0]  s_axil_wdata,
    input  logic [tracklet_pkg::AXI_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                                 s_axil_wvalid,
    output logic                                 s_axil_wready,
    output logic [1:0]                           s_axil_bresp,
    output logic                                 s_axil_bvalid,
    input  logic                                 s_axil_bready,
    input  logic [tracklet_pkg::AXI_ADDR_W-1:0]  s_axil_araddr,
    input  logic                                 s_axil_arvalid,
    output logic                                 s_axil_arready,
    output logic [tracklet_pkg::AXI_DATA_W-1:0]  s_axil_rdata,
    output logic [1:0]                           s_axil_rresp,
    output logic                                 s_axil_rvalid,
    input  logic                                 s_axil_rready
);
    import tracklet_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic [TRACK_W-1:0]    last_track;
    logic [AXI_DATA_W-1:0] pass_cnt, reject_cnt;
    logic [AXI_DATA_W-1:0] rd_mux;
    logic                  wr_start, wr_fire, clear_hit, ar_fire;

    assign s_axil_bresp = RESP_OKAY;
    assign s_axil_rresp = RESP_OKAY;

    ////////////////////////////////////////
    // write channel
    ////////////////////////////////////////
    // address and data only taken together, one at a time
    assign wr_start = s_axil_awvalid && s_axil_wvalid && !s_axil_awready && !s_axil_bvalid;
    assign wr_fire  = s_axil_awvalid && s_axil_awready;
    assign clear_hit = wr_fire && (s_axil_awaddr == REG_CLEAR) && (|s_axil_wstrb);

    always_ff @(posedge clk) begin
        if (reset) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
        end else begin
            s_axil_awready <= wr_start;     // single-cycle pulse
            s_axil_wready  <= wr_start;
            if (wr_fire)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // tracklet capture and counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (track_valid)
            last_track <= trackpar;
    end

    always_ff @(posedge clk) begin
        if (reset || clear_hit) begin       // clear beats a same-cycle count
            pass_cnt   <= '0;
            reject_cnt <= '0;
        end else begin
            if (track_valid)
                pass_cnt <= pass_cnt + 1'b1;
            if (track_reject)
                reject_cnt <= reject_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // read channel
    ////////////////////////////////////////
    assign s_axil_arready = !s_axil_rvalid;
    assign ar_fire = s_axil_arvalid && s_axil_arready;

    always_comb begin
        case (s_axil_araddr)
            REG_TRACK_LO:   rd_mux = last_track[AXI_DATA_W-1:0];
            REG_TRACK_HI:   rd_mux = AXI_DATA_W'(last_track[TRACK_W-1:AXI_DATA_W]);
            REG_PASS_CNT:   rd_mux = pass_cnt;
            REG_REJECT_CNT: rd_mux = reject_cnt;
            default:        rd_mux = '0;    // unmapped and clear read as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            s_axil_rvalid <= 1'b0;
        else if (ar_fire)
            s_axil_rvalid <= 1'b1;
        else if (s_axil_rready)
            s_axil_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            s_axil_rdata <= rd_mux;
    end

    rdata_held: assert property (
        @(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata)
    );

endmodule

`default_nettype wire

/* hw/tracklet_calculator.sv */
`default_nettype none

module tracklet_calculator #(
    parameter int KR_INNER = 981,
    parameter int KR_OUTER = 1515,
    parameter int KZ_INNER = 981,
    parameter int KZ_OUTER = 1515,
    parameter int RINV_CUT = 7491,
    parameter int Z0_CUT   = 267
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  stub_valid,
    input  logic [tracklet_pkg::STUB_W-1:0]       inner_stub,
    input  logic [tracklet_pkg::STUB_W-1:0]       outer_stub,
    output logic                                  track_valid,
    output logic [tracklet_pkg::TRACK_W-1:0]      trackpar,
    input  logic [tracklet_pkg::AXI_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                                  s_axil_awvalid,
    output logic                                  s_axil_awready,
    input  logic [tracklet_pkg::AXI_DATA_W-1:0]   s_axil_wdata,
    input  logic [tracklet_pkg::AXI_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                                  s_axil_wvalid,
    output logic                                  s_axil_wready,
    output logic [1:0]                            s_axil_bresp,
    output logic                                  s_axil_bvalid,
    input  logic                                  s_axil_bready,
    input  logic [tracklet_pkg::AXI_ADDR_W-1:0]   s_axil_araddr,
    input  logic                                  s_axil_arvalid,
    output logic                                  s_axil_arready,
    output logic [tracklet_pkg::AXI_DATA_W-1:0]   s_axil_rdata,
    output logic [1:0]                            s_axil_rresp,
    output logic                                  s_axil_rvalid,
    input  logic                                  s_axil_rready
);
    import tracklet_pkg::*;

    logic signed [RINV_W-1:0] rinv;
    logic signed [T_W-1:0]    t;
    logic                     track_reject;

    stub_delta_if delta ();

    stub_pair_front #(
        .KR_INNER (KR_INNER),
        .KR_OUTER (KR_OUTER),
        .KZ_INNER (KZ_INNER),
        .KZ_OUTER (KZ_OUTER)
    ) front_i (
        .clk        (clk),
        .reset      (reset),
        .stub_valid (stub_valid),
        .inner_stub (inner_stub),
        .outer_stub (outer_stub),
        .delta      (delta.front)
    );

    // curvature and slope run side by side on the same deltas
    curvature_unit curvature_i (.clk(clk), .delta(delta.sink), .rinv(rinv));
    slope_unit     slope_i     (.clk(clk), .delta(delta.sink), .t(t));

    track_param_combiner #(
        .RINV_CUT (RINV_CUT),
        .Z0_CUT   (Z0_CUT)
    ) combiner_i (
        .clk          (clk),
        .reset        (reset),
        .delta        (delta.sink),
        .rinv         (rinv),
        .t            (t),
        .track_valid  (track_valid),
        .track_reject (track_reject),
        .trackpar     (trackpar)
    );

    axil_track_regs regs_i (
        .clk            (clk),
        .reset          (reset),
        .track_valid    (track_valid),
        .track_reject   (track_reject),
        .trackpar       (trackpar),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

endmodule

`default_nettype wire

/* tests/tracklet_model.svh */
`ifndef TRACKLET_MODEL_SVH
`define TRACKLET_MODEL_SVH

// geometry constants, same values as the DUT defaults
localparam int KR_INNER = 981;
localparam int KR_OUTER = 1515;
localparam int KZ_INNER = 981;
localparam int KZ_OUTER = 1515;
localparam int RINV_CUT = 7491;
localparam int Z0_CUT   = 267;

////////////////////////////////////////
// reference model
////////////////////////////////////////
function automatic int rom_value(input int addr);
    int q;
    q = (1 << DRINV_SHIFT) / ((addr == 0) ? 1 : addr);
    return (q > 4095) ? 4095 : q;
endfunction

function automatic logic [STUB_W-1:0] make_stub(input int r, input int z, input int phi);
    logic [STUB_W-1:0] s;
    s = '0;
    s[R_LSB +: R_W]     = R_W'(r);
    s[Z_LSB +: Z_W]     = Z_W'(z);
    s[PHI_LSB +: PHI_W] = PHI_W'(phi);
    return s;
endfunction

task automatic model_pair(input logic [STUB_W-1:0] a, input logic [STUB_W-1:0] b,
                          output logic pass, output logic [TRACK_W-1:0] par);
    int ra, rb, za, zb, pa, pb, ra_abs, rb_abs, drinv;
    logic signed [DPHI_W-1:0] dphi;
    logic signed [DZ_W-1:0]   dz;
    logic signed [RINV_W-1:0] rinv;
    logic signed [T_W-1:0]    t;
    logic signed [PHI0_W-1:0] phi0;
    logic signed [Z0_W-1:0]   z0;
    ra = $signed(a[R_LSB +: R_W]);
    rb = $signed(b[R_LSB +: R_W]);
    za = $signed(a[Z_LSB +: Z_W]);
    zb = $signed(b[Z_LSB +: Z_W]);
    pa = a[PHI_LSB +: PHI_W];
    pb = b[PHI_LSB +: PHI_W];
    ra_abs = (KR_INNER + ra) & ((1 << RABS_W) - 1);
    rb_abs = (KR_OUTER + rb) & ((1 << RABS_W) - 1);
    drinv  = rom_value((rb_abs - ra_abs) & ((1 << DRINV_ADDR_W) - 1));
    dphi = DPHI_W'(pb - pa);
    dz   = DZ_W'((KZ_OUTER - KZ_INNER) + (zb - za));
    rinv = RINV_W'(-((int'(dphi) * drinv) >>> RINV_SHIFT));
    t    = T_W'((int'(dz) * drinv) >>> T_SHIFT);
    phi0 = PHI0_W'(pa + ((int'(rinv) * ra_abs) >>> PROJ_SHIFT));
    z0   = Z0_W'(za - ((int'(t) * ra_abs) >>> PROJ_SHIFT));
    pass = (rinv < RINV_CUT) && (rinv > -RINV_CUT) && (z0 < Z0_CUT) && (z0 > -Z0_CUT);
    par  = {rinv, phi0, z0, t};
endtask

////////////////////////////////////////
// compare tasks
////////////////////////////////////////
task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic check_track(input string name, input logic [TRACK_W-1:0] exp,
                           input logic [TRACK_W-1:0] act);
    if (act !== exp)
        report_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                 $time, name, exp, act));
endtask

task automatic check_data(input string name, input logic [AXI_DATA_W-1:0] exp,
                          input logic [AXI_DATA_W-1:0] act);
    if (act !== exp)
        report_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                 $time, name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
        report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                                 $time, name, exp, act));
endtask

`endif

/* tests/tb_tracklet_calculator.sv */
`default_nettype none

module tb_tracklet_calculator;
    timeunit 1ns;
    timeprecision 1ps;
    import tracklet_pkg::*;

    localparam int N_PAIRS    = 400;
    localparam int N_DIRECTED = 6;
    localparam int N_AXI      = 12;
    localparam int WATCHDOG_CYCLES = (N_PAIRS + N_DIRECTED + N_AXI) * 20;

    logic clk, reset, stub_valid, track_valid;
    logic [STUB_W-1:0]       inner_stub, outer_stub;
    logic [TRACK_W-1:0]      trackpar;
    logic [AXI_ADDR_W-1:0]   s_axil_awaddr, s_axil_araddr;
    logic [AXI_DATA_W-1:0]   s_axil_wdata, s_axil_rdata;
    logic [AXI_DATA_W/8-1:0] s_axil_wstrb;
    logic [1:0]              s_axil_bresp, s_axil_rresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic s_axil_rvalid, s_axil_rready;

    // scoreboard state
    logic               vin_pipe [6];
    logic               pass_pipe [6];
    logic [TRACK_W-1:0] par_pipe [6];
    logic               mdl_pass;
    logic [TRACK_W-1:0] mdl_par, last_pass;
    logic               have_pass;
    int                 pass_count, reject_count;
    logic [AXI_DATA_W-1:0] rd;

    `include "tracklet_model.svh"

    tracklet_calculator tracklet_calculator_i (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // bus and stimulus tasks
    ////////////////////////////////////////
    task automatic drive_pair(input logic v, input logic [STUB_W-1:0] a,
                              input logic [STUB_W-1:0] b);
        @(posedge clk);
        stub_valid <= v;
        inner_stub <= a;
        outer_stub <= b;
    endtask

    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        int hold;
        hold = $urandom_range(3);
        @(posedge clk);
        s_axil_awaddr  <= addr;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= '1;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        do @(negedge clk); while (!s_axil_awready);
        check_bit("s_axil_wready", 1'b1, s_axil_wready);
        @(posedge clk);
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        @(negedge clk);
        check_bit("s_axil_bvalid", 1'b1, s_axil_bvalid);
        check_data("s_axil_bresp", '0, AXI_DATA_W'(s_axil_bresp));
        check_bit("s_axil_awready", 1'b0, s_axil_awready);     // one-cycle pulse
        check_bit("s_axil_wready", 1'b0, s_axil_wready);
        repeat (hold) begin
            @(negedge clk);
            check_bit("s_axil_bvalid", 1'b1, s_axil_bvalid);   // held while stalled
        end
        @(posedge clk) s_axil_bready <= 1'b1;
        @(posedge clk) s_axil_bready <= 1'b0;
        @(negedge clk);
        check_bit("s_axil_bvalid", 1'b0, s_axil_bvalid);
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr,
                             output logic [AXI_DATA_W-1:0] data);
        int hold;
        logic [AXI_DATA_W-1:0] first;
        hold = $urandom_range(3);
        @(posedge clk);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        do @(negedge clk); while (!s_axil_arready);
        @(posedge clk) s_axil_arvalid <= 1'b0;
        @(negedge clk);
        check_bit("s_axil_rvalid", 1'b1, s_axil_rvalid);
        check_data("s_axil_rresp", '0, AXI_DATA_W'(s_axil_rresp));
        check_bit("s_axil_arready", 1'b0, s_axil_arready);     // blocked while pending
        first = s_axil_rdata;
        repeat (hold) begin
            @(negedge clk);
            check_bit("s_axil_rvalid", 1'b1, s_axil_rvalid);
            check_bit("s_axil_arready", 1'b0, s_axil_arready);
            check_data("s_axil_rdata", first, s_axil_rdata);
        end
        @(posedge clk) s_axil_rready <= 1'b1;
        @(posedge clk) s_axil_rready <= 1'b0;
        @(negedge clk);
        check_bit("s_axil_rvalid", 1'b0, s_axil_rvalid);
        check_bit("s_axil_arready", 1'b1, s_axil_arready);
        data = first;
    endtask

    task automatic directed_pair(input int ra, input int rb, input int pa, input int pb,
                                 input logic expect_pass);
        logic p;
        logic [TRACK_W-1:0] par;
        model_pair(make_stub(ra, 0, pa), make_stub(rb, 0, pb), p, par);
        if (p !== expect_pass)
            report_failure("directed pair does not land on the intended side of the cut");
        drive_pair(1'b1, make_stub(ra, 0, pa), make_stub(rb, 0, pb));
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////
    always @(posedge clk) begin
        model_pair(inner_stub, outer_stub, mdl_pass, mdl_par);
        if (reset) begin
            for (int i = 0; i < 6; i++)
                vin_pipe[i] <= 1'b0;
        end else begin
            for (int i = 5; i > 0; i--) begin
                vin_pipe[i]  <= vin_pipe[i-1];
                pass_pipe[i] <= pass_pipe[i-1];
                par_pipe[i]  <= par_pipe[i-1];
            end
            vin_pipe[0]  <= stub_valid;
            pass_pipe[0] <= mdl_pass;
            par_pipe[0]  <= mdl_par;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_bit("track_valid", vin_pipe[5] && pass_pipe[5], track_valid);
            if (vin_pipe[5] && pass_pipe[5]) begin
                check_track("trackpar", par_pipe[5], trackpar);
                last_pass = par_pipe[5];
                have_pass = 1'b1;
                pass_count++;
            end else begin
                if (vin_pipe[5])
                    reject_count++;
                if (have_pass)
                    check_track("trackpar", last_pass, trackpar);   // held between tracks
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        report_failure("watchdog timeout: the test did not finish in time");
    end

    initial begin
        int ra, rb, pa, pb;
        clk = 1'b0;
        reset = 1'b1;
        stub_valid = 1'b0;
        inner_stub = '0;
        outer_stub = '0;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        have_pass = 1'b0;
        last_pass = '0;
        pass_count = 0;
        reject_count = 0;
        void'($urandom(13));
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_bit("track_valid", 1'b0, track_valid);
        check_bit("s_axil_awready", 1'b0, s_axil_awready);
        check_bit("s_axil_wready", 1'b0, s_axil_wready);
        check_bit("s_axil_bvalid", 1'b0, s_axil_bvalid);
        check_bit("s_axil_rvalid", 1'b0, s_axil_rvalid);
        check_bit("s_axil_arready", 1'b1, s_axil_arready);
        axil_read(REG_PASS_CNT, rd);
        check_data("pass_cnt", '0, rd);
        axil_read(REG_REJECT_CNT, rd);
        check_data("reject_cnt", '0, rd);

        // random batch, outer radius always beyond inner
        for (int n = 0; n < N_PAIRS; n++) begin
            ra = int'($urandom_range(1000)) - 900;
            rb = int'($urandom_range(600)) - 100;
            pa = $urandom_range(16383);
            pb = ($urandom_range(1) == 1) ? $urandom_range(16383)
                                          : (pa + int'($urandom_range(600)) - 300) & 16'h3fff;
            drive_pair($urandom_range(3) != 0,
                       make_stub(ra, int'($urandom_range(127)) - 64, pa),
                       make_stub(rb, int'($urandom_range(127)) - 64, pb));
        end
        drive_pair(1'b0, '0, '0);
        repeat (8) @(posedge clk);

        axil_read(REG_PASS_CNT, rd);
        check_data("pass_cnt", AXI_DATA_W'(pass_count), rd);
        axil_read(REG_REJECT_CNT, rd);
        check_data("reject_cnt", AXI_DATA_W'(reject_count), rd);
        if (have_pass) begin
            axil_read(REG_TRACK_LO, rd);
            check_data("track_lo", last_pass[AXI_DATA_W-1:0], rd);
            axil_read(REG_TRACK_HI, rd);
            check_data("track_hi", AXI_DATA_W'(last_pass[TRACK_W-1:AXI_DATA_W]), rd);
        end

        // dr = 512 gives rinv = -dphi, edges of both cuts
        directed_pair(-900, -922, 8000, 15490, 1'b1);
        directed_pair(-900, -922, 8000, 15491, 1'b0);
        directed_pair(-900, -922, 8000, 510, 1'b1);
        directed_pair(-900, -922, 8000, 509, 1'b0);
        directed_pair(-726, -748, 100, 100, 1'b1);   // z0 = -265
        directed_pair(-725, -747, 100, 100, 1'b0);   // z0 = -267
        drive_pair(1'b0, '0, '0);
        repeat (8) @(posedge clk);
        axil_read(REG_PASS_CNT, rd);
        check_data("pass_cnt", AXI_DATA_W'(pass_count), rd);

        // counters and tracklet are nonzero here
        axil_read(8'h20, rd);
        check_data("unmapped read", '0, rd);

        axil_write(REG_CLEAR, $urandom);
        pass_count = 0;
        reject_count = 0;
        axil_read(REG_PASS_CNT, rd);
        check_data("pass_cnt", '0, rd);
        axil_read(REG_REJECT_CNT, rd);
        check_data("reject_cnt", '0, rd);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tests
hw/tracklet_pkg.sv
hw/stub_delta_if.sv
hw/stub_pair_front.sv
hw/curvature_unit.sv
hw/slope_unit.sv
hw/track_param_combiner.sv
hw/axil_track_regs.sv
hw/tracklet_calculator.sv
tests/tb_tracklet_calculator.sv

/* Makefile */
# Verilator build and run for the tracklet calculator

TOP       ?= tb_tracklet_calculator
VERILATOR ?= verilator
SEED_ARGS ?= +verilator+seed+13
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
